// ==== src/rs_pkg.sv ====
`default_nettype none

package rs_pkg;

	// Three architectural registers R0 to R2
	parameter int NUM_REGS = 3;

	// Entry index width, enough for up to four entries
	parameter int ENTRY_W = 2;

	// Register identifier, code 3 names no register
	typedef logic [1:0] reg_id_t;

	// Register and result value
	typedef logic [9:0] value_t;

	// Immediate, zero-extended into value_t at issue
	typedef logic [3:0] imm_t;

	// Operation codes shared by issue and dispatch
	typedef enum logic [2:0] {
		OP_ADD   = 3'd0,
		OP_SUB   = 3'd1,
		OP_LOAD  = 3'd2,
		OP_STORE = 3'd3
	} op_t;

	// Dispatch payload for the add/sub unit
	typedef struct packed {
		op_t                  op;
		reg_id_t              dest;
		value_t               opnd1;
		value_t               opnd2;
		logic [ENTRY_W-1:0]   entry;
	} alu_payload_t;

	// Dispatch payload for the load/store unit, opnd1 carries the immediate
	typedef struct packed {
		op_t                  op;
		reg_id_t              dest;
		value_t               opnd1;
		value_t               opnd2;
		logic [ENTRY_W-1:0]   entry;
	} mem_payload_t;

endpackage

`default_nettype wire

// ==== src/reg_status.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_status (
	input  logic             clock,
	input  logic             rst_n,
	input  logic             issue_valid,
	input  rs_pkg::reg_id_t  issue_rx,
	input  rs_pkg::reg_id_t  src_a_reg,
	input  rs_pkg::reg_id_t  src_b_reg,
	input  rs_pkg::value_t   reg_r0,
	input  rs_pkg::value_t   reg_r1,
	input  rs_pkg::value_t   reg_r2,
	input  logic             cdb_valid,
	input  rs_pkg::reg_id_t  cdb_reg,
	input  logic             dest_still_pending,
	output logic             src_a_ready,
	output logic             src_b_ready,
	output rs_pkg::value_t   src_a_value,
	output rs_pkg::value_t   src_b_value
);
	import rs_pkg::*;

	// One flag per register, set while some entry will write it
	logic [NUM_REGS-1:0] waiting;

	// Register file values, indexed by register id
	value_t reg_vals [NUM_REGS];

	assign reg_vals = '{reg_r0, reg_r1, reg_r2};

	// Flag update
	// Issue sets the flag of RX and wins over a CDB clear on the same edge
	// A CDB clears only when no other busy entry targets the register
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			waiting <= '0;
		end else begin
			for (int i = 0; i < NUM_REGS; i++) begin
				if (issue_valid && issue_rx == reg_id_t'(i)) begin
					waiting[i] <= 1'b1;
				end else if (cdb_valid && cdb_reg == reg_id_t'(i) && !dest_still_pending) begin
					waiting[i] <= 1'b0;
				end
			end
		end
	end

	// Operand read at issue, purely combinational
	// Unknown register id reads as ready with value zero
	always_comb begin
		src_a_ready = 1'b1;
		src_b_ready = 1'b1;
		src_a_value = '0;
		src_b_value = '0;
		for (int i = 0; i < NUM_REGS; i++) begin
			if (src_a_reg == reg_id_t'(i)) begin
				src_a_ready = !waiting[i];
				src_a_value = reg_vals[i];
			end
			if (src_b_reg == reg_id_t'(i)) begin
				src_b_ready = !waiting[i];
				src_b_value = reg_vals[i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/unit_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module unit_select #(
	parameter int  NUM_ENTRIES = 3,
	parameter type payload_t   = logic
) (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic [NUM_ENTRIES-1:0]      ready_mask,
	input  payload_t                    cands [NUM_ENTRIES],
	input  logic                        done,
	output logic                        taken,
	output logic [rs_pkg::ENTRY_W-1:0]  taken_entry,
	output logic                        disp_valid,
	output payload_t                    disp_payload
);
	import rs_pkg::*;

	// Unit holds one operation from dispatch until its CDB result
	logic               unit_busy;
	logic               pick_found;
	logic [ENTRY_W-1:0] pick_idx;
	payload_t           pick_payload;

	// Lowest ready candidate of this class
	always_comb begin
		pick_found   = 1'b0;
		pick_idx     = '0;
		pick_payload = cands[0];
		for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
			if (ready_mask[i]) begin
				pick_found   = 1'b1;
				pick_idx     = ENTRY_W'(i);
				pick_payload = cands[i];
			end
		end
	end

	// Table marks the entry on the same edge the dispatch registers
	assign taken       = !unit_busy && pick_found;
	assign taken_entry = pick_idx;

	// Busy tracker and one-cycle dispatch strobe
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			unit_busy  <= 1'b0;
			disp_valid <= 1'b0;
		end else begin
			disp_valid <= taken;
			if (taken) begin
				unit_busy <= 1'b1;
			end else if (done) begin
				unit_busy <= 1'b0;
			end
		end
	end

	// Payload only meaningful with disp_valid
	always_ff @(posedge clock) begin
		if (taken) begin
			disp_payload <= pick_payload;
		end
	end

endmodule

`default_nettype wire

// ==== src/rs_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_table #(
	parameter int NUM_ENTRIES = 3
) (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic                        issue_valid,
	input  rs_pkg::op_t                 issue_op,
	input  rs_pkg::reg_id_t             issue_rx,
	input  rs_pkg::reg_id_t             issue_ry,
	input  rs_pkg::reg_id_t             issue_rz,
	input  rs_pkg::imm_t                issue_imm,
	input  logic                        cdb_valid,
	input  rs_pkg::reg_id_t             cdb_reg,
	input  logic [rs_pkg::ENTRY_W-1:0]  cdb_entry,
	input  rs_pkg::value_t              cdb_value,
	input  logic                        src_a_ready,
	input  logic                        src_b_ready,
	input  rs_pkg::value_t              src_a_value,
	input  rs_pkg::value_t              src_b_value,
	input  logic                        alu_taken,
	input  logic                        mem_taken,
	input  logic [rs_pkg::ENTRY_W-1:0]  alu_taken_entry,
	input  logic [rs_pkg::ENTRY_W-1:0]  mem_taken_entry,
	output rs_pkg::reg_id_t             src_a_reg,
	output rs_pkg::reg_id_t             src_b_reg,
	output logic                        dest_still_pending,
	output logic [NUM_ENTRIES-1:0]      alu_ready_mask,
	output logic [NUM_ENTRIES-1:0]      mem_ready_mask,
	output rs_pkg::alu_payload_t        alu_cands [NUM_ENTRIES],
	output rs_pkg::mem_payload_t        mem_cands [NUM_ENTRIES],
	output logic                        stall
);
	import rs_pkg::*;

	// Control columns
	logic [NUM_ENTRIES-1:0] busy;
	logic [NUM_ENTRIES-1:0] dispatched;
	logic [NUM_ENTRIES-1:0] pend_a;
	logic [NUM_ENTRIES-1:0] pend_b;

	// Payload columns
	op_t     op_q   [NUM_ENTRIES];
	reg_id_t dest_q [NUM_ENTRIES];
	value_t  val_a  [NUM_ENTRIES];
	value_t  val_b  [NUM_ENTRIES];
	reg_id_t tag_a  [NUM_ENTRIES];
	reg_id_t tag_b  [NUM_ENTRIES];

	// Allocation and wakeup decode
	logic [NUM_ENTRIES-1:0] free_vec;
	logic [NUM_ENTRIES-1:0] wake_a;
	logic [NUM_ENTRIES-1:0] wake_b;
	logic [ENTRY_W-1:0]     alloc_idx;
	logic                   alloc_en;
	logic                   issue_mem;
	logic                   bypass_a;
	logic                   bypass_b;
	logic                   new_pend_a;
	logic                   new_pend_b;
	value_t                 new_val_a;
	value_t                 new_val_b;
	reg_id_t                new_tag_b;

	// Sources are always RY and RZ, load/store only uses RY
	assign src_a_reg = issue_ry;
	assign src_b_reg = issue_rz;

	assign issue_mem = (issue_op == OP_LOAD) || (issue_op == OP_STORE);

	// A result on the same edge that releases the register feeds the new entry
	assign bypass_a = cdb_valid && !dest_still_pending && cdb_reg == issue_ry;
	assign bypass_b = cdb_valid && !dest_still_pending && cdb_reg == issue_rz;

	// Operand build for the entry being issued
	always_comb begin
		if (issue_mem) begin
			// Immediate in operand one, RY in operand two
			new_pend_a = 1'b0;
			new_val_a  = value_t'(issue_imm);
			new_pend_b = !src_a_ready && !bypass_a;
			new_val_b  = src_a_ready ? src_a_value : cdb_value;
			new_tag_b  = issue_ry;
		end else begin
			new_pend_a = !src_a_ready && !bypass_a;
			new_val_a  = src_a_ready ? src_a_value : cdb_value;
			new_pend_b = !src_b_ready && !bypass_b;
			new_val_b  = src_b_ready ? src_b_value : cdb_value;
			new_tag_b  = issue_rz;
		end
	end

	// CDB completion frees its slot before allocation looks
	always_comb begin
		alloc_idx = '0;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			free_vec[i] = !busy[i] || (cdb_valid && cdb_entry == ENTRY_W'(i));
			wake_a[i]   = cdb_valid && pend_a[i] && tag_a[i] == cdb_reg;
			wake_b[i]   = cdb_valid && pend_b[i] && tag_b[i] == cdb_reg;
		end
		// Lowest free slot wins
		for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
			if (free_vec[i]) begin
				alloc_idx = ENTRY_W'(i);
			end
		end
	end

	assign alloc_en = issue_valid && (|free_vec);

	// Busy entries other than the completing one that still target cdb_reg
	always_comb begin
		dest_still_pending = 1'b0;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			if (busy[i] && cdb_entry != ENTRY_W'(i) && dest_q[i] == cdb_reg) begin
				dest_still_pending = 1'b1;
			end
		end
	end

	// Control state, later writes take priority within the edge
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			busy       <= '0;
			dispatched <= '0;
			pend_a     <= '0;
			pend_b     <= '0;
		end else begin
			for (int i = 0; i < NUM_ENTRIES; i++) begin
				if (cdb_valid && cdb_entry == ENTRY_W'(i)) begin
					busy[i] <= 1'b0;
				end
				if (wake_a[i]) begin
					pend_a[i] <= 1'b0;
				end
				if (wake_b[i]) begin
					pend_b[i] <= 1'b0;
				end
				if ((alu_taken && alu_taken_entry == ENTRY_W'(i)) ||
					(mem_taken && mem_taken_entry == ENTRY_W'(i))) begin
					dispatched[i] <= 1'b1;
				end
				// New issue overrides whatever the slot held
				if (alloc_en && alloc_idx == ENTRY_W'(i)) begin
					busy[i]       <= 1'b1;
					dispatched[i] <= 1'b0;
					pend_a[i]     <= new_pend_a;
					pend_b[i]     <= new_pend_b;
				end
			end
		end
	end

	// Payload columns, captured on wakeup and on allocation
	always_ff @(posedge clock) begin
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			if (wake_a[i]) begin
				val_a[i] <= cdb_value;
			end
			if (wake_b[i]) begin
				val_b[i] <= cdb_value;
			end
			if (alloc_en && alloc_idx == ENTRY_W'(i)) begin
				op_q[i]   <= issue_op;
				dest_q[i] <= issue_rx;
				val_a[i]  <= new_val_a;
				val_b[i]  <= new_val_b;
				tag_a[i]  <= issue_ry;
				tag_b[i]  <= new_tag_b;
			end
		end
	end

	// Ready vectors and candidate payloads per unit class
	always_comb begin
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			alu_ready_mask[i] = busy[i] && !dispatched[i] && !pend_a[i] && !pend_b[i] &&
				(op_q[i] == OP_ADD || op_q[i] == OP_SUB);
			mem_ready_mask[i] = busy[i] && !dispatched[i] && !pend_a[i] && !pend_b[i] &&
				(op_q[i] == OP_LOAD || op_q[i] == OP_STORE);
			alu_cands[i] = '{op: op_q[i], dest: dest_q[i], opnd1: val_a[i],
				opnd2: val_b[i], entry: ENTRY_W'(i)};
			mem_cands[i] = '{op: op_q[i], dest: dest_q[i], opnd1: val_a[i],
				opnd2: val_b[i], entry: ENTRY_W'(i)};
		end
	end

	// Full table blocks the issuer
	assign stall = &busy;

endmodule

`default_nettype wire

// ==== src/rs_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_top #(
	parameter int NUM_ENTRIES = 3
) (
	input  logic                        clock,
	input  logic                        rst_n,
	// Issue side
	input  logic                        issue_valid,
	input  rs_pkg::op_t                 issue_op,
	input  rs_pkg::reg_id_t             issue_rx,
	input  rs_pkg::reg_id_t             issue_ry,
	input  rs_pkg::reg_id_t             issue_rz,
	input  rs_pkg::imm_t                issue_imm,
	input  rs_pkg::value_t              reg_r0,
	input  rs_pkg::value_t              reg_r1,
	input  rs_pkg::value_t              reg_r2,
	// Common data bus
	input  logic                        cdb_valid,
	input  rs_pkg::reg_id_t             cdb_reg,
	input  logic [rs_pkg::ENTRY_W-1:0]  cdb_entry,
	input  logic                        cdb_from_alu,
	input  rs_pkg::value_t              cdb_value,
	// Dispatch to the two units
	output logic                        alu_valid,
	output rs_pkg::alu_payload_t        alu_payload,
	output logic                        mem_valid,
	output rs_pkg::mem_payload_t        mem_payload,
	output logic                        stall
);
	import rs_pkg::*;

	// Operand read path at issue
	reg_id_t            src_a_reg;
	reg_id_t            src_b_reg;
	logic               src_a_ready;
	logic               src_b_ready;
	value_t             src_a_value;
	value_t             src_b_value;
	logic               dest_still_pending;

	// Table to selector traffic
	logic [NUM_ENTRIES-1:0] alu_ready_mask;
	logic [NUM_ENTRIES-1:0] mem_ready_mask;
	alu_payload_t           alu_cands [NUM_ENTRIES];
	mem_payload_t           mem_cands [NUM_ENTRIES];
	logic                   alu_taken;
	logic                   mem_taken;
	logic [ENTRY_W-1:0]     alu_taken_entry;
	logic [ENTRY_W-1:0]     mem_taken_entry;

	reg_status u_reg_status (
		.clock              (clock),
		.rst_n              (rst_n),
		.issue_valid        (issue_valid),
		.issue_rx           (issue_rx),
		.src_a_reg          (src_a_reg),
		.src_b_reg          (src_b_reg),
		.reg_r0             (reg_r0),
		.reg_r1             (reg_r1),
		.reg_r2             (reg_r2),
		.cdb_valid          (cdb_valid),
		.cdb_reg            (cdb_reg),
		.dest_still_pending (dest_still_pending),
		.src_a_ready        (src_a_ready),
		.src_b_ready        (src_b_ready),
		.src_a_value        (src_a_value),
		.src_b_value        (src_b_value)
	);

	rs_table #(
		.NUM_ENTRIES (NUM_ENTRIES)
	) u_rs_table (
		.clock              (clock),
		.rst_n              (rst_n),
		.issue_valid        (issue_valid),
		.issue_op           (issue_op),
		.issue_rx           (issue_rx),
		.issue_ry           (issue_ry),
		.issue_rz           (issue_rz),
		.issue_imm          (issue_imm),
		.cdb_valid          (cdb_valid),
		.cdb_reg            (cdb_reg),
		.cdb_entry          (cdb_entry),
		.cdb_value          (cdb_value),
		.src_a_ready        (src_a_ready),
		.src_b_ready        (src_b_ready),
		.src_a_value        (src_a_value),
		.src_b_value        (src_b_value),
		.alu_taken          (alu_taken),
		.mem_taken          (mem_taken),
		.alu_taken_entry    (alu_taken_entry),
		.mem_taken_entry    (mem_taken_entry),
		.src_a_reg          (src_a_reg),
		.src_b_reg          (src_b_reg),
		.dest_still_pending (dest_still_pending),
		.alu_ready_mask     (alu_ready_mask),
		.mem_ready_mask     (mem_ready_mask),
		.alu_cands          (alu_cands),
		.mem_cands          (mem_cands),
		.stall              (stall)
	);

	// Add/sub unit, released by a CDB result flagged as ALU
	unit_select #(
		.NUM_ENTRIES (NUM_ENTRIES),
		.payload_t   (alu_payload_t)
	) u_alu_select (
		.clock        (clock),
		.rst_n        (rst_n),
		.ready_mask   (alu_ready_mask),
		.cands        (alu_cands),
		.done         (cdb_valid && cdb_from_alu),
		.taken        (alu_taken),
		.taken_entry  (alu_taken_entry),
		.disp_valid   (alu_valid),
		.disp_payload (alu_payload)
	);

	// Load/store unit
	unit_select #(
		.NUM_ENTRIES (NUM_ENTRIES),
		.payload_t   (mem_payload_t)
	) u_mem_select (
		.clock        (clock),
		.rst_n        (rst_n),
		.ready_mask   (mem_ready_mask),
		.cands        (mem_cands),
		.done         (cdb_valid && !cdb_from_alu),
		.taken        (mem_taken),
		.taken_entry  (mem_taken_entry),
		.disp_valid   (mem_valid),
		.disp_payload (mem_payload)
	);

endmodule

`default_nettype wire

// ==== verif/rs_top_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_top_assert (
	input logic clock,
	input logic rst_n,
	input logic stall,
	input logic alu_valid,
	input logic mem_valid,
	input logic cdb_valid,
	input logic cdb_from_alu
);

	// Failed assertion count
	int failures = 0;

	// Unit holds an operation between its dispatch and its CDB result
	logic alu_out;
	logic mem_out;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			alu_out <= 1'b0;
			mem_out <= 1'b0;
		end else begin
			if (alu_valid) begin
				alu_out <= 1'b1;
			end else if (cdb_valid && cdb_from_alu) begin
				alu_out <= 1'b0;
			end
			if (mem_valid) begin
				mem_out <= 1'b1;
			end else if (cdb_valid && !cdb_from_alu) begin
				mem_out <= 1'b0;
			end
		end
	end

	// Quiet right out of reset
	reset_quiet: assert property (@(posedge clock)
		$rose(rst_n) |-> !stall && !alu_valid && !mem_valid)
		else begin
			failures++;
			$error("stall or dispatch active right after reset");
		end

	// Strobes last one cycle
	alu_one_cycle: assert property (@(posedge clock) disable iff (!rst_n)
		alu_valid |=> !alu_valid)
		else begin
			failures++;
			$error("add/sub dispatch strobe longer than one cycle");
		end

	mem_one_cycle: assert property (@(posedge clock) disable iff (!rst_n)
		mem_valid |=> !mem_valid)
		else begin
			failures++;
			$error("load/store dispatch strobe longer than one cycle");
		end

	// No second dispatch before the CDB result of the first
	alu_no_redispatch: assert property (@(posedge clock) disable iff (!rst_n)
		alu_valid |-> !alu_out)
		else begin
			failures++;
			$error("add/sub unit dispatched while still busy");
		end

	mem_no_redispatch: assert property (@(posedge clock) disable iff (!rst_n)
		mem_valid |-> !mem_out)
		else begin
			failures++;
			$error("load/store unit dispatched while still busy");
		end

endmodule

bind rs_top rs_top_assert u_rs_top_assert (.*);

`default_nettype wire

// ==== verif/rs_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_top_tb;
	import rs_pkg::*;

	localparam int NUM_ENTRIES   = 3;
	localparam int CLK_HALF      = 20;
	localparam int DISPATCH_WAIT = 20;

	// DUT inputs
	logic           clock;
	logic           rst_n;
	logic           issue_valid;
	op_t            issue_op;
	reg_id_t        issue_rx;
	reg_id_t        issue_ry;
	reg_id_t        issue_rz;
	imm_t           issue_imm;
	value_t         reg_r0;
	value_t         reg_r1;
	value_t         reg_r2;
	logic           cdb_valid;
	reg_id_t        cdb_reg;
	logic [ENTRY_W-1:0] cdb_entry;
	logic           cdb_from_alu;
	value_t         cdb_value;

	// DUT outputs
	logic           alu_valid;
	alu_payload_t   alu_payload;
	logic           mem_valid;
	mem_payload_t   mem_payload;
	logic           stall;

	// Command lines from the cases file without its comment lines
	string          case_lines [$];
	logic           cases_loaded;

	// Dispatches seen on each unit in arrival order
	alu_payload_t   alu_seen [$];
	mem_payload_t   mem_seen [$];

	// Run bookkeeping
	int             checks;
	int             errors;
	int             tests_run;
	int             tests_failed;
	int             test_errors;
	string          test_name;

	rs_top #(
		.NUM_ENTRIES (NUM_ENTRIES)
	) u_dut (
		.clock        (clock),
		.rst_n        (rst_n),
		.issue_valid  (issue_valid),
		.issue_op     (issue_op),
		.issue_rx     (issue_rx),
		.issue_ry     (issue_ry),
		.issue_rz     (issue_rz),
		.issue_imm    (issue_imm),
		.reg_r0       (reg_r0),
		.reg_r1       (reg_r1),
		.reg_r2       (reg_r2),
		.cdb_valid    (cdb_valid),
		.cdb_reg      (cdb_reg),
		.cdb_entry    (cdb_entry),
		.cdb_from_alu (cdb_from_alu),
		.cdb_value    (cdb_value),
		.alu_valid    (alu_valid),
		.alu_payload  (alu_payload),
		.mem_valid    (mem_valid),
		.mem_payload  (mem_payload),
		.stall        (stall)
	);

	// 40 ns clock
	initial begin
		clock = 1'b0;
		forever #CLK_HALF clock = ~clock;
	end

	// Dispatch monitor samples on the falling edge away from the driving edge
	always @(negedge clock) begin
		if (rst_n) begin
			if (alu_valid) begin
				alu_seen.push_back(alu_payload);
			end
			if (mem_valid) begin
				mem_seen.push_back(mem_payload);
			end
		end
	end

	// Strip trailing LF and CR characters
	function automatic string trim_eol(input string s);
		string t;
		t = s;
		while (t.len() > 0 &&
			(t.getc(t.len() - 1) == 8'h0a || t.getc(t.len() - 1) == 8'h0d)) begin
			t = t.substr(0, t.len() - 2);
		end
		return t;
	endfunction

	task automatic check_value(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			test_errors++;
			$display("Fail %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
		end
	endtask

	// One result line for the test that just ended
	task automatic close_test();
		if (test_name.len() > 0) begin
			tests_run++;
			if (test_errors == 0) begin
				$display("Test %s: passed", test_name);
			end else begin
				tests_failed++;
				$display("Test %s: failed with %0d errors", test_name, test_errors);
			end
		end
		test_errors = 0;
	endtask

	// One-cycle issue strobe sampled on the following edge
	task automatic send_issue(input logic [31:0] op, input logic [31:0] rx,
		input logic [31:0] ry, input logic [31:0] rz, input logic [31:0] imm,
		input logic [31:0] r0, input logic [31:0] r1, input logic [31:0] r2);
		@(posedge clock);
		issue_valid <= 1'b1;
		issue_op    <= op_t'(op[2:0]);
		issue_rx    <= rx[1:0];
		issue_ry    <= ry[1:0];
		issue_rz    <= rz[1:0];
		issue_imm   <= imm[3:0];
		reg_r0      <= r0[9:0];
		reg_r1      <= r1[9:0];
		reg_r2      <= r2[9:0];
		@(posedge clock);
		issue_valid <= 1'b0;
	endtask

	// One-cycle result broadcast
	task automatic send_cdb(input logic [31:0] rid, input logic [31:0] entry,
		input logic [31:0] from_alu, input logic [31:0] value);
		@(posedge clock);
		cdb_valid    <= 1'b1;
		cdb_reg      <= rid[1:0];
		cdb_entry    <= entry[ENTRY_W-1:0];
		cdb_from_alu <= from_alu[0];
		cdb_value    <= value[9:0];
		@(posedge clock);
		cdb_valid    <= 1'b0;
	endtask

	// Bounded wait for the next dispatch of one unit
	task automatic expect_dispatch(input logic on_alu, input logic [63:0] expected);
		int waited;
		int pending;
		logic [63:0] got;
		waited = 0;
		pending = on_alu ? alu_seen.size() : mem_seen.size();
		while (pending == 0 && waited < DISPATCH_WAIT) begin
			@(posedge clock);
			waited++;
			pending = on_alu ? alu_seen.size() : mem_seen.size();
		end
		if (pending == 0) begin
			errors++;
			test_errors++;
			$display("Test %s: no %s dispatch arrived within %0d cycles", test_name,
				on_alu ? "add/sub" : "load/store", DISPATCH_WAIT);
		end else if (on_alu) begin
			got = 64'(alu_seen.pop_front());
			check_value("add/sub dispatch", expected, got);
		end else begin
			got = 64'(mem_seen.pop_front());
			check_value("load/store dispatch", expected, got);
		end
	endtask

	task automatic expect_stall(input logic expected);
		@(negedge clock);
		check_value("stall", 64'(expected), 64'(stall));
	endtask

	task automatic run_command(input string line);
		byte          cmd;
		string        rest;
		int           n;
		logic [31:0]  f0, f1, f2, f3, f4, f5, f6, f7;
		alu_payload_t exp_pl;
		cmd  = line.getc(0);
		rest = line.substr(2, line.len() - 1);
		n    = 0;
		case (cmd)
			"T": begin
				close_test();
				test_name = rest;
			end
			"I": begin
				n = $sscanf(rest, "%h %h %h %h %h %h %h %h", f0, f1, f2, f3, f4, f5, f6, f7);
				if (n == 8) begin
					send_issue(f0, f1, f2, f3, f4, f5, f6, f7);
				end
			end
			"C": begin
				n = $sscanf(rest, "%h %h %h %h", f0, f1, f2, f3);
				if (n == 4) begin
					send_cdb(f0, f1, f2, f3);
				end
			end
			"A", "M": begin
				n = $sscanf(rest, "%h %h %h %h %h", f0, f1, f2, f3, f4);
				// Both payload types share one field layout
				exp_pl.op    = op_t'(f0[2:0]);
				exp_pl.dest  = f1[1:0];
				exp_pl.opnd1 = f2[9:0];
				exp_pl.opnd2 = f3[9:0];
				exp_pl.entry = f4[ENTRY_W-1:0];
				if (n == 5) begin
					expect_dispatch(cmd == "A", 64'(exp_pl));
				end
			end
			"S": begin
				n = $sscanf(rest, "%h", f0);
				if (n == 1) begin
					expect_stall(f0[0]);
				end
			end
			default: begin
				n = -1;
			end
		endcase
		// Any short or unknown line counts as an error
		if ((cmd != "T" && n <= 0) || (cmd == "I" && n != 8) || (cmd == "C" && n != 4) ||
			((cmd == "A" || cmd == "M") && n != 5)) begin
			errors++;
			test_errors++;
			$display("Could not parse case line: %s", line);
		end
	endtask

	initial begin
		int    fd;
		string line;
		// Every DUT input starts at a known value
		rst_n        = 1'b0;
		issue_valid  = 1'b0;
		issue_op     = OP_ADD;
		issue_rx     = '0;
		issue_ry     = '0;
		issue_rz     = '0;
		issue_imm    = '0;
		reg_r0       = '0;
		reg_r1       = '0;
		reg_r2       = '0;
		cdb_valid    = 1'b0;
		cdb_reg      = '0;
		cdb_entry    = '0;
		cdb_from_alu = 1'b0;
		cdb_value    = '0;
		checks       = 0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		test_errors  = 0;
		test_name    = "";
		cases_loaded = 1'b0;
		fd = $fopen("verif/rs_top_cases.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open verif/rs_top_cases.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				line = trim_eol(line);
				if (line.len() > 0 && line.getc(0) != "#") begin
					case_lines.push_back(line);
				end
			end
			$fclose(fd);
		end
		cases_loaded = 1'b1;
		// Reset for four cycles
		repeat (4) @(posedge clock);
		rst_n <= 1'b1;
		@(posedge clock);
		foreach (case_lines[i]) begin
			run_command(case_lines[i]);
		end
		close_test();
		// Anything left in the queues was never expected
		repeat (4) @(posedge clock);
		if (alu_seen.size() != 0 || mem_seen.size() != 0) begin
			errors++;
			$display("Unexpected dispatches left over: %0d add/sub, %0d load/store",
				alu_seen.size(), mem_seen.size());
		end
		if (u_dut.u_rs_top_assert.failures != 0) begin
			errors += u_dut.u_rs_top_assert.failures;
			$display("Bound assertions failed %0d times", u_dut.u_rs_top_assert.failures);
		end
		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog scaled to the number of case lines
	initial begin
		longint limit_ns;
		wait (cases_loaded === 1'b1);
		limit_ns = longint'(CLK_HALF * 2) * longint'(case_lines.size() + 50) * 4;
		#(limit_ns);
		$display("Watchdog expired after %0d ns, the run did not finish", limit_ns);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/rs_top_cases.txt ====
# Hex fields. I op rx ry rz imm r0 r1 r2 / C reg entry from_alu value / S stall / T test name
# A (add/sub) and M (load/store) expect a dispatch: op dest opnd1 opnd2 entry
T add_ready
I 0 2 0 1 0 011 022 033
A 0 2 011 022 0
C 2 0 1 055
S 0
T sub_waits_on_tag
I 0 1 0 2 0 011 022 033
A 0 1 011 033 0
I 1 0 1 2 0 011 022 033
C 1 0 1 044
A 1 0 044 033 1
C 0 1 1 011
T load_beside_pending_alu
I 0 2 1 1 0 011 022 033
A 0 2 022 022 0
I 1 1 2 0 0 011 022 033
I 2 0 0 0 5 011 022 033
S 1
M 2 0 005 011 2
C 0 2 0 077
S 0
C 2 0 1 066
A 1 1 066 011 1
C 1 1 1 0aa
T stall_and_slot_reuse
I 0 0 1 2 0 011 022 033
A 0 0 022 033 0
I 2 1 2 0 3 011 022 033
M 2 1 003 033 1
I 3 2 1 0 4 011 022 033
S 1
C 1 1 0 0bb
S 0
M 3 2 004 0bb 2
I 1 1 2 0 0 011 022 033
S 1
C 0 0 1 0cc
C 2 2 0 0dd
A 1 1 0dd 0cc 1
C 1 1 1 0ee
S 0
T two_producers_same_reg
I 0 1 0 0 0 011 022 033
A 0 1 011 011 0
I 1 1 2 2 0 011 022 033
C 1 0 1 0f0
A 1 1 033 033 1
I 0 0 1 2 0 011 022 033
C 1 1 1 1f1
A 0 0 1f1 033 0
C 0 0 1 000
S 0

// ==== rs_top.f ====
src/rs_pkg.sv
src/reg_status.sv
src/unit_select.sv
src/rs_table.sv
src/rs_top.sv
verif/rs_top_assert.sv
verif/rs_top_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the reservation station testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f rs_top.f --top-module rs_top_tb -o rs_top_sim || exit 1
sim_out=$(./obj_dir/rs_top_sim)
echo "$sim_out"
echo "$sim_out" | grep -q "TEST RESULT: PASS" && exit 0 || exit 1
